//--- common/servant_pkg.sv
package servant_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Wishbone classic bus
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Request from a master, held stable while cyc is high
   typedef struct packed {
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
      logic        we;
      logic        cyc;
   } wb_req_t;

   typedef struct packed {
      logic [31:0] rdt;
      logic        ack;   // Single cycle pulse
   } wb_rsp_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Address map
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   typedef struct packed {
      logic [1:0]  region;
      logic [27:0] offset;     // Word offset inside the region
      logic [1:0]  byte_ofs;
   } bus_addr_dec_t;

   // The mux looks at the region, the slaves at the word offset
   typedef union packed {
      logic [31:0]   raw;
      bus_addr_dec_t dec;
   } bus_addr_u;

   localparam logic [1:0] REGION_RAM   = 2'd0;
   localparam logic [1:0] REGION_GPIO  = 2'd1;
   localparam logic [1:0] REGION_TIMER = 2'd2;
   // Region 3 has no slave behind it

   // RAM depth in 32 bit words
   localparam int MEM_WORDS = 2048;

   // Timer registers, as word offsets inside the timer region
   localparam logic [27:0] TIMER_CNT_OFS = 28'd0;
   localparam logic [27:0] TIMER_CMP_OFS = 28'd1;

endpackage

//--- design/servant_arbiter.sv
`timescale 1ns/1ps

module servant_arbiter import servant_pkg::*; (
   input  logic    i_wb_clk,
   input  logic    i_rst_n,
   input  wb_req_t i_dbus,
   output wb_rsp_t o_dbus,
   input  wb_req_t i_ibus,
   output wb_rsp_t o_ibus,
   output wb_req_t o_ram,
   input  wb_rsp_t i_ram
);

   logic gnt_dbus_q;   // Owner of the RAM bus, set for the data bus
   logic gnt_held_q;   // Grant taken and waiting for the RAM ack

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Grant
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // A new grant is only taken on an idle RAM bus, and the data bus wins a tie
   always_ff @(posedge i_wb_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         gnt_dbus_q <= 1'b0;
         gnt_held_q <= 1'b0;
      end else if (!gnt_held_q) begin
         if (i_dbus.cyc) begin
            gnt_dbus_q <= 1'b1;
            gnt_held_q <= 1'b1;
         end else if (i_ibus.cyc) begin
            gnt_dbus_q <= 1'b0;
            gnt_held_q <= 1'b1;
         end
      end else if (i_ram.ack) begin
         gnt_held_q <= 1'b0;   // The master drops cyc in the next cycle
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Request and response steering
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb begin
      if (gnt_dbus_q) begin
         o_ram = i_dbus;
      end else begin
         o_ram     = i_ibus;
         o_ram.dat = '0;
         o_ram.sel = 4'hf;
         o_ram.we  = 1'b0;   // Instruction fetches only read
      end
      o_ram.cyc = gnt_held_q & (gnt_dbus_q ? i_dbus.cyc : i_ibus.cyc);
   end

   assign o_dbus.rdt = i_ram.rdt;
   assign o_dbus.ack = i_ram.ack & gnt_dbus_q;
   assign o_ibus.rdt = i_ram.rdt;
   assign o_ibus.ack = i_ram.ack & ~gnt_dbus_q;

endmodule

//--- design/servant_mux.sv
`timescale 1ns/1ps

module servant_mux import servant_pkg::*; (
   input  logic        i_wb_clk,
   input  logic        i_rst_n,
   input  wb_req_t     i_cpu,
   output wb_rsp_t     o_cpu,
   output wb_req_t     o_mem,
   input  wb_rsp_t     i_mem,
   output wb_req_t     o_per,
   output logic        o_per_sel_timer,
   input  logic [31:0] i_per_rdt
);

   bus_addr_u addr;
   logic      hit_mem;
   logic      hit_per;
   logic      ack_q;   // Local ack for everything outside RAM

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Region decode
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign addr.raw = i_cpu.adr;

   assign hit_mem = (addr.dec.region == REGION_RAM);
   assign hit_per = (addr.dec.region == REGION_GPIO) |
                    (addr.dec.region == REGION_TIMER);

   assign o_per_sel_timer = (addr.dec.region == REGION_TIMER);

   // Each target sees the request, but only the decoded one sees cyc
   always_comb begin
      o_mem     = i_cpu;
      o_mem.cyc = i_cpu.cyc & hit_mem;
   end

   always_comb begin
      o_per     = i_cpu;
      o_per.cyc = i_cpu.cyc & hit_per;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Response
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Peripherals and the unmapped region answer one cycle after cyc
   always_ff @(posedge i_wb_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= i_cpu.cyc & ~hit_mem & ~ack_q;
      end
   end

   always_comb begin
      if (hit_mem) begin
         o_cpu = i_mem;   // RAM timing comes from the arbiter and RAM
      end else begin
         o_cpu.ack = ack_q;
         o_cpu.rdt = hit_per ? i_per_rdt : '0;
      end
   end

endmodule

//--- design/servant_ram.sv
`timescale 1ns/1ps

module servant_ram import servant_pkg::*; #(
   parameter int DEPTH = MEM_WORDS
) (
   input  logic    i_wb_clk,
   input  logic    i_rst_n,
   input  wb_req_t i_req,
   output wb_rsp_t o_rsp
);

   logic [31:0]              mem [DEPTH];
   bus_addr_u                addr;
   logic [$clog2(DEPTH)-1:0] idx;
   logic [31:0]              rdt_q;
   logic                     ack_q;

   assign addr.raw = i_req.adr;
   assign idx      = addr.dec.offset[$clog2(DEPTH)-1:0];   // Upper offset bits alias

   // Write lanes once, in the first cycle of the access
   always_ff @(posedge i_wb_clk) begin
      if (i_req.cyc && i_req.we && !ack_q) begin
         for (int i = 0; i < 4; i++) begin
            if (i_req.sel[i]) begin
               mem[idx][8*i +: 8] <= i_req.dat[8*i +: 8];
            end
         end
      end
      rdt_q <= mem[idx];
   end

   // Ack follows cyc by one cycle and drops again right after
   always_ff @(posedge i_wb_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= i_req.cyc & ~ack_q;
      end
   end

   assign o_rsp.rdt = rdt_q;
   assign o_rsp.ack = ack_q;

endmodule

//--- design/servant_periph.sv
`timescale 1ns/1ps

module servant_periph import servant_pkg::*; (
   input  logic        i_wb_clk,
   input  logic        i_rst_n,
   input  wb_req_t     i_req,
   input  logic        i_sel_timer,
   output logic [31:0] o_rdt,
   output logic [7:0]  o_gpio,
   output logic        o_timer_irq
);

   bus_addr_u   addr;
   logic        wr_gpio;
   logic        wr_cmp;
   logic [7:0]  gpio_q;
   logic [31:0] cnt_q;
   logic [31:0] cmp_q;
   logic        irq_q;

   assign addr.raw = i_req.adr;

   // The write lands at the edge before the ack, so the acked cycle sees it
   assign wr_gpio = i_req.cyc & i_req.we & ~i_sel_timer & i_req.sel[0];
   assign wr_cmp  = i_req.cyc & i_req.we & i_sel_timer &
                    (addr.dec.offset == TIMER_CMP_OFS);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // GPIO
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge i_wb_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         gpio_q <= '0;
      end else if (wr_gpio) begin
         gpio_q <= i_req.dat[7:0];
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Machine timer
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge i_wb_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cnt_q <= '0;
         cmp_q <= '1;   // Far away, so no interrupt until software sets it
         irq_q <= 1'b0;
      end else begin
         cnt_q <= cnt_q + 32'd1;
         irq_q <= (cnt_q >= cmp_q);
         for (int i = 0; i < 4; i++) begin
            if (wr_cmp && i_req.sel[i]) begin
               cmp_q[8*i +: 8] <= i_req.dat[8*i +: 8];
            end
         end
      end
   end

   always_comb begin
      o_rdt = '0;
      if (!i_sel_timer) begin
         o_rdt = {24'd0, gpio_q};
      end else begin
         case (addr.dec.offset)
            TIMER_CNT_OFS: o_rdt = cnt_q;
            TIMER_CMP_OFS: o_rdt = cmp_q;
            default:       o_rdt = '0;
         endcase
      end
   end

   assign o_gpio      = gpio_q;
   assign o_timer_irq = irq_q;

endmodule

//--- design/servant.sv
`timescale 1ns/1ps

module servant import servant_pkg::*; (
   input  logic       i_wb_clk,
   input  logic       i_rst_n,
   // Instruction bus from the CPU
   input  wb_req_t    i_ibus,
   output wb_rsp_t    o_ibus,
   // Data bus from the CPU
   input  wb_req_t    i_dbus,
   output wb_rsp_t    o_dbus,
   output logic [7:0] o_gpio,
   output logic       o_timer_irq
);

   wb_req_t     dmem_req;   // RAM side of the data mux
   wb_rsp_t     dmem_rsp;
   wb_req_t     ram_req;    // Arbitrated RAM bus
   wb_rsp_t     ram_rsp;
   wb_req_t     per_req;
   logic        per_sel_timer;
   logic [31:0] per_rdt;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Bus fabric
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   servant_mux mux (
      .i_wb_clk        (i_wb_clk),
      .i_rst_n         (i_rst_n),
      .i_cpu           (i_dbus),
      .o_cpu           (o_dbus),
      .o_mem           (dmem_req),
      .i_mem           (dmem_rsp),
      .o_per           (per_req),
      .o_per_sel_timer (per_sel_timer),
      .i_per_rdt       (per_rdt)
   );

   servant_arbiter arbiter (
      .i_wb_clk (i_wb_clk),
      .i_rst_n  (i_rst_n),
      .i_dbus   (dmem_req),
      .o_dbus   (dmem_rsp),
      .i_ibus   (i_ibus),
      .o_ibus   (o_ibus),
      .o_ram    (ram_req),
      .i_ram    (ram_rsp)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Slaves
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   servant_ram #(
      .DEPTH (MEM_WORDS)
   ) ram (
      .i_wb_clk (i_wb_clk),
      .i_rst_n  (i_rst_n),
      .i_req    (ram_req),
      .o_rsp    (ram_rsp)
   );

   servant_periph periph (
      .i_wb_clk    (i_wb_clk),
      .i_rst_n     (i_rst_n),
      .i_req       (per_req),
      .i_sel_timer (per_sel_timer),
      .o_rdt       (per_rdt),
      .o_gpio      (o_gpio),
      .o_timer_irq (o_timer_irq)
   );

endmodule

//--- bench/servant_sva.sv
`timescale 1ns/1ps

module servant_sva import servant_pkg::*; (
   input logic    i_wb_clk,
   input logic    i_rst_n,
   input wb_req_t i_ibus,
   input wb_rsp_t o_ibus,
   input wb_req_t i_dbus,
   input wb_rsp_t o_dbus
);

   int fail_count = 0;   // Picked up by the testbench

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Wishbone classic handshake
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   ibus_ack_needs_cyc : assert property (
      @(posedge i_wb_clk) disable iff (!i_rst_n) o_ibus.ack |-> i_ibus.cyc
   ) else begin
      fail_count++;
      $error("Instruction bus ack without cyc");
   end

   dbus_ack_needs_cyc : assert property (
      @(posedge i_wb_clk) disable iff (!i_rst_n) o_dbus.ack |-> i_dbus.cyc
   ) else begin
      fail_count++;
      $error("Data bus ack without cyc");
   end

   // Ack is a single cycle pulse
   ibus_ack_pulse : assert property (
      @(posedge i_wb_clk) disable iff (!i_rst_n) o_ibus.ack |=> !o_ibus.ack
   ) else begin
      fail_count++;
      $error("Instruction bus ack held for two cycles");
   end

   dbus_ack_pulse : assert property (
      @(posedge i_wb_clk) disable iff (!i_rst_n) o_dbus.ack |=> !o_dbus.ack
   ) else begin
      fail_count++;
      $error("Data bus ack held for two cycles");
   end

   one_ack_at_a_time : assert property (
      @(posedge i_wb_clk) disable iff (!i_rst_n) !(o_ibus.ack && o_dbus.ack)
   ) else begin
      fail_count++;
      $error("Both buses acked in the same cycle");
   end

endmodule

bind servant servant_sva sva0 (
   .i_wb_clk (i_wb_clk),
   .i_rst_n  (i_rst_n),
   .i_ibus   (i_ibus),
   .o_ibus   (o_ibus),
   .i_dbus   (i_dbus),
   .o_dbus   (o_dbus)
);

//--- bench/servant_tb.sv
`timescale 1ns/1ps

module servant_tb import servant_pkg::*; ();

   localparam int          FIELDS    = 6;   // Words per golden line
   localparam int          MAX_LINES = 64;
   localparam int          ACK_WAIT  = 16;
   localparam logic [31:0] LFSR_SEED = 32'h42a6_508a;

   logic        clk;
   logic        rst_n;
   wb_req_t     ibus;
   wb_req_t     dbus;
   wb_rsp_t     ibus_rsp;
   wb_rsp_t     dbus_rsp;
   logic [7:0]  gpio;
   logic        timer_irq;

   logic [31:0] golden [FIELDS*MAX_LINES];
   logic [31:0] ram_model [int unsigned];   // Keyed by RAM word index
   logic [7:0]  gpio_model    = '0;
   logic [31:0] lfsr          = LFSR_SEED;
   int unsigned cycle_count   = 0;
   int unsigned cycle_limit   = 0;
   int          data_errors   = 0;
   int          ack_errors    = 0;
   int          golden_errors = 0;

   servant dut0 (
      .i_wb_clk    (clk),
      .i_rst_n     (rst_n),
      .i_ibus      (ibus),
      .o_ibus      (ibus_rsp),
      .i_dbus      (dbus),
      .o_dbus      (dbus_rsp),
      .o_gpio      (gpio),
      .o_timer_irq (timer_irq)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) cycle_count <= cycle_count + 1;

   initial begin
      while (cycle_limit == 0 || cycle_count < cycle_limit) begin
         @(posedge clk);
      end
      $display("Run reached the cycle limit of %0d before the end of the golden file",
               cycle_limit);
      $display("*** FAILED ***");
      $finish;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Helpers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
   endfunction

   task automatic take_bits(input int count, output int value);
      value = 0;
      for (int i = 0; i < count; i++) begin
         value = (value << 1) | int'(lfsr[0]);
         lfsr  = lfsr_next(lfsr);
      end
   endtask

   // One classic cycle with cyc held until ack and dropped in the cycle after it
   task automatic bus_access(input logic on_dbus, input logic we, input logic [3:0] sel,
                             input logic [31:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdt, output int unsigned ack_at);
      wb_req_t req;
      wb_rsp_t rsp;
      int      waited;
      req    = '{adr: addr, dat: wdata, sel: sel, we: we, cyc: 1'b1};
      waited = 0;
      @(posedge clk);
      #1;
      if (on_dbus) dbus = req;
      else ibus = req;
      do begin
         @(negedge clk);   // Responses are settled half a cycle after the edge
         rsp = on_dbus ? dbus_rsp : ibus_rsp;
         waited++;
      end while (!rsp.ack && waited < ACK_WAIT);
      assert (rsp.ack) else begin
         ack_errors++;
         $display("No ack on the %s bus within %0d cycles for address %h",
                  on_dbus ? "data" : "instruction", ACK_WAIT, addr);
      end
      rdt    = rsp.rdt;
      ack_at = cycle_count;
      @(posedge clk);
      #1;
      req.cyc = 1'b0;
      if (on_dbus) dbus = req;
      else ibus = req;
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected) else begin
         data_errors++;
         $display("FAILED %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic model_write(input logic [3:0] sel, input logic [31:0] addr,
                              input logic [31:0] wdata);
      int unsigned idx;
      logic [31:0] word;
      idx  = int'(addr[29:2]) % MEM_WORDS;   // RAM aliases above its depth
      word = ram_model.exists(idx) ? ram_model[idx] : 32'd0;
      for (int i = 0; i < 4; i++) begin
         if (sel[i]) begin
            word[8*i +: 8] = wdata[8*i +: 8];
         end
      end
      if (addr[31:30] == REGION_RAM) begin
         ram_model[idx] = word;
      end else if (addr[31:30] == REGION_GPIO && sel[0]) begin
         gpio_model = wdata[7:0];
      end
   endtask

   // The golden file has to agree with the model wherever the model knows the value
   task automatic confirm_golden(input string name, input logic [31:0] addr,
                                 input logic [31:0] expected);
      int unsigned idx;
      logic [31:0] model;
      logic        known;
      idx   = int'(addr[29:2]) % MEM_WORDS;
      known = 1'b1;
      model = 32'd0;   // Unmapped region reads as zero
      if (addr[31:30] == REGION_RAM) begin
         known = (ram_model.exists(idx) != 0);
         model = known ? ram_model[idx] : 32'd0;
      end else if (addr[31:30] == REGION_GPIO) begin
         model = {24'd0, gpio_model};
      end else if (addr[31:30] == REGION_TIMER) begin
         known = 1'b0;
      end
      if (known) begin
         assert (model === expected) else begin
            golden_errors++;
            $display("%s: golden file expects %h, the model holds %h", name, expected, model);
         end
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Golden replay
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   initial begin
      string       name;
      logic [31:0] op;
      logic        we;
      logic [3:0]  sel;
      logic [31:0] adr;
      logic [31:0] dat;
      logic [31:0] expected;
      logic [31:0] got;
      logic [31:0] got_i;
      int unsigned at_d;
      int unsigned at_i;
      int          lines;
      int          idle;
      int          pair;
      int          errors;
      rst_n = 1'b0;
      ibus  = '0;
      dbus  = '0;
      $readmemh("bench/servant_golden.mem", golden);
      lines = 0;
      while (lines < MAX_LINES && golden[FIELDS*lines] != 32'hf) begin
         lines++;
      end
      cycle_limit = lines * 20 + 200;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;

      for (int n = 0; n < lines; n++) begin
         op       = golden[FIELDS*n];
         we       = golden[FIELDS*n+1][0];
         sel      = golden[FIELDS*n+2][3:0];
         adr      = golden[FIELDS*n+3];
         dat      = golden[FIELDS*n+4];
         expected = golden[FIELDS*n+5];
         name     = $sformatf("line %0d op %0h addr %h", n + 1, op, adr);
         take_bits(2, idle);
         repeat (idle) @(posedge clk);
         case (op)
            32'h0: begin   // Instruction fetch
               bus_access(1'b0, 1'b0, sel, adr, 32'd0, got, at_i);
               confirm_golden(name, adr, expected);
               check_value(name, expected, got);
            end
            32'h1: begin
               bus_access(1'b1, we, sel, adr, dat, got, at_d);
               if (we) begin
                  model_write(sel, adr, dat);
               end else begin
                  confirm_golden(name, adr, expected);
                  check_value(name, expected, got);
               end
            end
            32'h2: begin
               take_bits(1, pair);
               if (pair != 0) begin
                  fork
                     bus_access(1'b1, 1'b0, sel, adr, 32'd0, got, at_d);
                     bus_access(1'b0, 1'b0, sel, adr, 32'd0, got_i, at_i);
                  join
                  assert (at_d < at_i) else begin
                     ack_errors++;
                     $display("%s: instruction bus acked at cycle %0d, %s %0d",
                              name, at_i, "not after data bus at", at_d);
                  end
               end else begin
                  bus_access(1'b1, 1'b0, sel, adr, 32'd0, got, at_d);
                  bus_access(1'b0, 1'b0, sel, adr, 32'd0, got_i, at_i);
               end
               confirm_golden(name, adr, expected);
               check_value({name, " dbus"}, expected, got);
               check_value({name, " ibus"}, expected, got_i);
            end
            32'h3: begin   // Counter still below the compare value in the expect column
               bus_access(1'b1, 1'b0, sel, adr, 32'd0, got, at_d);
               assert (got < expected) else begin
                  data_errors++;
                  $display("FAILED %s expected below %h actual %h", name, expected, got);
               end
               @(negedge clk);
               check_value({name, " irq"}, 32'd0, {31'd0, timer_irq});
            end
            32'h4: begin
               do begin
                  bus_access(1'b1, 1'b0, sel, adr, 32'd0, got, at_d);
               end while (got < expected);
               @(negedge clk);
               check_value({name, " irq"}, 32'd1, {31'd0, timer_irq});
            end
            32'h5: begin
               @(negedge clk);
               check_value({name, " irq"}, expected, {31'd0, timer_irq});
            end
            32'h6: begin
               @(negedge clk);
               confirm_golden(name, 32'h4000_0000, expected);
               check_value({name, " gpio"}, expected, {24'd0, gpio});
            end
            default: begin
               golden_errors++;
               $display("%s: unknown operation code in the golden file", name);
            end
         endcase
      end

      repeat (2) @(posedge clk);
      errors = data_errors + ack_errors + golden_errors + dut0.sva0.fail_count;
      $display("Errors: data %0d, ack %0d, golden %0d, protocol %0d",
               data_errors, ack_errors, golden_errors, dut0.sva0.fail_count);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- bench/servant_golden.mem
// op we sel addr wdata expect, all hex
// op 0 ibus read, 1 dbus access, 2 read on both buses, 3 counter below expect,
// op 4 poll counter up to expect, 5 irq equals expect, 6 gpio equals expect, f end
5 0 0 00000000 00000000 00000000
1 1 f 00000000 11223344 00000000
1 0 f 00000000 00000000 11223344
1 1 f 00000004 a5a5a5a5 00000000
1 1 1 00000004 000000ff 00000000
1 0 f 00000004 00000000 a5a5a5ff
1 1 6 00000004 12cdef34 00000000
1 0 f 00000004 00000000 a5cdefff
1 1 8 00000004 77000000 00000000
1 0 f 00000004 00000000 77cdefff
1 1 f 00001ffc 13579bdf 00000000
1 1 3 00001ffc 0000aaaa 00000000
1 0 f 00001ffc 00000000 1357aaaa
1 1 f 00000100 00000013 00000000
1 1 f 00000104 00a00093 00000000
0 0 f 00000100 00000000 00000013
0 0 f 00000104 00000000 00a00093
0 0 f 00000000 00000000 11223344
2 0 f 00000004 00000000 77cdefff
2 0 f 00000100 00000000 00000013
2 0 f 00001ffc 00000000 1357aaaa
2 0 f 00000104 00000000 00a00093
1 1 1 40000000 000000a5 00000000
6 0 0 00000000 00000000 000000a5
1 0 f 40000000 00000000 000000a5
1 1 e 40000000 0000005a 00000000
1 0 f 40000000 00000000 000000a5
1 1 f 40000000 ffffff3c 00000000
6 0 0 00000000 00000000 0000003c
1 0 f 40000000 00000000 0000003c
1 0 f c0000000 00000000 00000000
1 0 f c0000010 00000000 00000000
1 1 f c0000000 ffffffff 00000000
1 0 f c0000000 00000000 00000000
1 1 f 80000004 00000200 00000000
1 0 f 80000004 00000000 00000200
3 0 f 80000000 00000000 00000200
4 0 f 80000000 00000000 00000200
1 1 f 80000004 ffffffff 00000000
5 0 0 00000000 00000000 00000000
1 0 f 80000004 00000000 ffffffff
f 0 0 00000000 00000000 00000000

//--- files.f
common/servant_pkg.sv
design/servant_arbiter.sv
design/servant_mux.sv
design/servant_ram.sv
design/servant_periph.sv
design/servant.sv
bench/servant_sva.sv
bench/servant_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= servant_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
LOG       ?= sim.log
PASS_MSG  ?= *** PASSED ***
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100

SRCS   := $(shell grep -v '^+' $(FILELIST))
GOLDEN := bench/servant_golden.mem
BIN    := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) $(GOLDEN)
	./$(BIN) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG)

check: run
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
